//--- rtl/sat_pkg.sv
package sat_pkg;

    // Rectangle size fields, halved to give the extents
    localparam int size_w = 8;
    localparam int half_w = 7;

    // Centre positions carry 25 fraction bits
    localparam int pos_w    = 32;
    localparam int pos_frac = 25;

    // Unit axis components carry 14 fraction bits
    localparam int basis_w    = 16;
    localparam int basis_frac = 14;

    // Corners share the basis fraction, so positions drop the extra bits
    localparam int pos_to_corner_shift = pos_frac - basis_frac;
    localparam int corner_w            = half_w + basis_w;

    // Corner times axis, then back down to the position format
    localparam int prod_w     = corner_w + basis_w;
    localparam int proj_shift = 2 * basis_frac - pos_frac;
    localparam int proj_w     = 32;

    localparam int num_corners = 4;

    // Direction 0 projects A onto B, direction 1 projects B onto A
    localparam int num_dirs = 2;

    typedef struct packed {
        logic signed [basis_w-1:0] u_x;
        logic signed [basis_w-1:0] u_y;
        logic signed [basis_w-1:0] v_x;
        logic signed [basis_w-1:0] v_y;
    } basis_t;

    typedef struct packed {
        logic        [size_w-1:0] width;
        logic        [size_w-1:0] height;
        logic signed [pos_w-1:0]  pos_x;
        logic signed [pos_w-1:0]  pos_y;
        basis_t                   basis;
    } rect_t;

    typedef struct packed {
        logic signed [half_w-1:0] half_x;
        logic signed [half_w-1:0] half_y;
    } extent_t;

    typedef struct packed {
        logic signed [corner_w-1:0] x;
        logic signed [corner_w-1:0] y;
    } corner_t;

    // Corners relative to the target centre, with the target axes and extents
    typedef struct packed {
        logic                                        valid;
        corner_t [num_dirs-1:0][num_corners-1:0]     corners;
        basis_t  [num_dirs-1:0]                      axes;
        extent_t [num_dirs-1:0]                      extents;
    } decode_stage_t;

    typedef struct packed {
        logic signed [proj_w-1:0] u;
        logic signed [proj_w-1:0] v;
    } proj_point_t;

    // Corners in the target's uv frame
    typedef struct packed {
        logic                                          valid;
        proj_point_t [num_dirs-1:0][num_corners-1:0]   points;
        extent_t     [num_dirs-1:0]                    extents;
    } project_stage_t;

endpackage

//--- rtl/corner_decode.sv
module corner_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  sat_pkg::rect_t         rect_a,
    input  sat_pkg::rect_t         rect_b,
    output sat_pkg::decode_stage_t decoded
);

    import sat_pkg::*;

    // Index 0 is A and index 1 is B
    rect_t   rects [num_dirs];
    extent_t half  [num_dirs];

    // Centres brought to the corner format
    logic signed [corner_w-1:0] center_x [num_dirs];
    logic signed [corner_w-1:0] center_y [num_dirs];

    // Corners of the source rectangle, relative to the target centre
    corner_t rel_corner [num_dirs][num_corners];

    assign rects[0] = rect_a;
    assign rects[1] = rect_b;

    for (genvar d = 0; d < num_dirs; d++) begin : g_dir

        // Size halved with a plain right shift, so odd sizes round down
        assign half[d] = '{
            half_x: half_w'(rects[d].width >> 1),
            half_y: half_w'(rects[d].height >> 1)
        };

        assign center_x[d] = corner_w'(rects[d].pos_x >>> pos_to_corner_shift);
        assign center_y[d] = corner_w'(rects[d].pos_y >>> pos_to_corner_shift);

        for (genvar k = 0; k < num_corners; k++) begin : g_corner
            logic signed [corner_w-1:0] hu;
            logic signed [corner_w-1:0] hv;

            // Corner order (-,-) (-,+) (+,-) (+,+) along u and v
            assign hu = (k >= 2) ? half[d].half_x : -half[d].half_x;
            assign hv = (k % 2 == 1) ? half[d].half_y : -half[d].half_y;

            // Rotate the half extents, then move from own centre to target centre
            assign rel_corner[d][k] = '{
                x: hu * rects[d].basis.u_x + hv * rects[d].basis.v_x
                   + center_x[d] - center_x[num_dirs-1-d],
                y: hu * rects[d].basis.u_y + hv * rects[d].basis.v_y
                   + center_y[d] - center_y[num_dirs-1-d]
            };
        end

    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded.valid <= in_valid;
        end

        for (int d = 0; d < num_dirs; d++) begin
            for (int k = 0; k < num_corners; k++) begin
                decoded.corners[d][k] <= rel_corner[d][k];
            end
            // The target is the other rectangle of the pair
            decoded.axes[d]    <= rects[num_dirs-1-d].basis;
            decoded.extents[d] <= half[num_dirs-1-d];
        end
    end

endmodule

//--- rtl/axis_project.sv
module axis_project (
    input  logic                    clk,
    input  logic                    rst,
    input  sat_pkg::decode_stage_t  decoded,
    output sat_pkg::project_stage_t projected
);

    import sat_pkg::*;

    // Dot product of a corner with one axis, scaled to the position format
    function automatic logic signed [proj_w-1:0] project_axis(
        input corner_t                   c,
        input logic signed [basis_w-1:0] ax,
        input logic signed [basis_w-1:0] ay
    );
        logic signed [prod_w-1:0] dot;

        dot = c.x * ax + c.y * ay;
        return proj_w'(dot >>> proj_shift);
    endfunction

    proj_point_t points [num_dirs][num_corners];

    always_comb begin
        for (int d = 0; d < num_dirs; d++) begin
            for (int k = 0; k < num_corners; k++) begin
                points[d][k].u = project_axis(
                    decoded.corners[d][k],
                    decoded.axes[d].u_x,
                    decoded.axes[d].u_y
                );
                points[d][k].v = project_axis(
                    decoded.corners[d][k],
                    decoded.axes[d].v_x,
                    decoded.axes[d].v_y
                );
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            projected.valid <= 1'b0;
        end else begin
            projected.valid <= decoded.valid;
        end

        for (int d = 0; d < num_dirs; d++) begin
            for (int k = 0; k < num_corners; k++) begin
                projected.points[d][k] <= points[d][k];
            end
            // Extents ride along for the comparison stage
            projected.extents[d] <= decoded.extents[d];
        end
    end

endmodule

//--- rtl/separation_check.sv
module separation_check (
    input  logic                    clk,
    input  logic                    rst,
    input  sat_pkg::project_stage_t projected,
    output logic                    out_valid,
    output logic                    is_collision
);

    import sat_pkg::*;

    // Span of the source rectangle along each target axis
    logic signed [proj_w-1:0] min_u [num_dirs];
    logic signed [proj_w-1:0] max_u [num_dirs];
    logic signed [proj_w-1:0] min_v [num_dirs];
    logic signed [proj_w-1:0] max_v [num_dirs];

    // Target half extents in the projection format
    logic signed [proj_w-1:0] lim_u [num_dirs];
    logic signed [proj_w-1:0] lim_v [num_dirs];

    // Four separating-axis tests per direction
    logic [num_dirs-1:0][3:0] separated;

    always_comb begin
        for (int d = 0; d < num_dirs; d++) begin
            min_u[d] = projected.points[d][0].u;
            max_u[d] = projected.points[d][0].u;
            min_v[d] = projected.points[d][0].v;
            max_v[d] = projected.points[d][0].v;

            // Full reduction over every corner
            for (int k = 1; k < num_corners; k++) begin
                if (projected.points[d][k].u < min_u[d]) begin
                    min_u[d] = projected.points[d][k].u;
                end
                if (projected.points[d][k].u > max_u[d]) begin
                    max_u[d] = projected.points[d][k].u;
                end
                if (projected.points[d][k].v < min_v[d]) begin
                    min_v[d] = projected.points[d][k].v;
                end
                if (projected.points[d][k].v > max_v[d]) begin
                    max_v[d] = projected.points[d][k].v;
                end
            end
        end
    end

    always_comb begin
        for (int d = 0; d < num_dirs; d++) begin
            lim_u[d] = projected.extents[d].half_x <<< pos_frac;
            lim_v[d] = projected.extents[d].half_y <<< pos_frac;

            // Touching edges count as separated
            separated[d][0] = (min_u[d] >= lim_u[d]);
            separated[d][1] = (max_u[d] <= -lim_u[d]);
            separated[d][2] = (min_v[d] >= lim_v[d]);
            separated[d][3] = (max_v[d] <= -lim_v[d]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            is_collision <= 1'b0;
        end else begin
            out_valid <= projected.valid;
            // Result holds until the next pair completes
            if (projected.valid) begin
                is_collision <= ~(|separated);
            end
        end
    end

endmodule

//--- rtl/collision_detector.sv
module collision_detector (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  sat_pkg::rect_t rect_a,
    input  sat_pkg::rect_t rect_b,
    output logic           out_valid,
    output logic           is_collision
);

    import sat_pkg::*;

    // Stage registers between the three pipeline steps
    decode_stage_t  decoded;
    project_stage_t projected;

    // Corners of each rectangle around the other's centre
    corner_decode i_corner_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .rect_a   (rect_a),
        .rect_b   (rect_b),
        .decoded  (decoded)
    );

    // Corners into the target uv frame
    axis_project i_axis_project (
        .clk       (clk),
        .rst       (rst),
        .decoded   (decoded),
        .projected (projected)
    );

    // Min/max against the target extents, eight tests in all
    separation_check i_separation_check (
        .clk          (clk),
        .rst          (rst),
        .projected    (projected),
        .out_valid    (out_valid),
        .is_collision (is_collision)
    );

endmodule

//--- dv/clk_gen.sv
module clk_gen #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, first rising edge after half a period
    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

//--- dv/collision_detector_tb.sv
module collision_detector_tb;

    import sat_pkg::*;

    localparam int pipe_latency   = 3;
    localparam int result_timeout = 20;
    localparam int num_random     = 24;
    localparam int unit           = 1 << basis_frac;

    logic  clk;
    logic  rst;
    logic  in_valid;
    rect_t rect_a;
    rect_t rect_b;
    logic  out_valid;
    logic  is_collision;

    // Stimulus table
    string case_name [$];
    rect_t case_a    [$];
    rect_t case_b    [$];
    bit    case_exp  [$];

    // Pairs in flight, oldest first
    string pend_name [$];
    bit    pend_flag [$];
    int    pend_due  [$];

    // Last completed pair, whose flag must hold until the next result
    string last_name;
    bit    last_flag;
    bit    have_result = 1'b0;

    int       cycle_count = 0;
    int       pass_count  = 0;
    int       fail_count  = 0;
    bit       timed_out   = 1'b0;
    bit [31:0] rng_state;

    clk_gen #(.period(4)) i_clk_gen (
        .clk (clk)
    );

    collision_detector i_collision_detector (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .rect_a       (rect_a),
        .rect_b       (rect_b),
        .out_valid    (out_valid),
        .is_collision (is_collision)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic bit [31:0] xorshift32(input bit [31:0] state);
        bit [31:0] x;

        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_below(input int limit);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'(limit));
    endfunction

    // Integer centre, optional quarter turn of the uv frame
    function automatic rect_t make_rect(input int w, input int h, input int px, input int py,
                                        input bit rotated);
        rect_t r;

        r.width  = size_w'(w);
        r.height = size_w'(h);
        r.pos_x  = pos_w'(px * (1 << pos_frac));
        r.pos_y  = pos_w'(py * (1 << pos_frac));
        if (rotated) begin
            r.basis.u_x = '0;
            r.basis.u_y = basis_w'(unit);
            r.basis.v_x = basis_w'(-unit);
            r.basis.v_y = '0;
        end else begin
            r.basis.u_x = basis_w'(unit);
            r.basis.u_y = '0;
            r.basis.v_x = '0;
            r.basis.v_y = basis_w'(unit);
        end
        return r;
    endfunction

    // Axis-aligned boxes overlap when the centre gap is below the summed halves
    function automatic bit expected_collision(input int dx, input int dy,
                                              input int reach_x, input int reach_y);
        int adx;
        int ady;

        adx = (dx < 0) ? -dx : dx;
        ady = (dy < 0) ? -dy : dy;
        return (adx < reach_x) && (ady < reach_y);
    endfunction

    task automatic add_case(input string name, input rect_t a, input rect_t b, input bit exp);
        case_name.push_back(name);
        case_a.push_back(a);
        case_b.push_back(b);
        case_exp.push_back(exp);
    endtask

    task automatic add_directed_cases();
        // Halves A 5,3 and B 4,4 give reach 9 in x and 7 in y
        add_case("aa_overlap", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 5, 3, 0), 1'b1);
        add_case("aa_sep_x", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 10, 0, 0), 1'b0);
        add_case("aa_sep_y", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 0, -8, 0), 1'b0);
        add_case("aa_touch_x", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 9, 0, 0), 1'b0);
        add_case("aa_touch_y", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 2, -7, 0), 1'b0);
        add_case("aa_inside", make_rect(10, 6, 0, 0, 0), make_rect(8, 8, 8, 6, 0), 1'b1);
        // Odd sizes floor to the same halves, so this still only touches
        add_case("aa_odd_sizes", make_rect(11, 7, 0, 0, 0), make_rect(9, 9, 9, 0, 0), 1'b0);
        add_case("aa_contained", make_rect(30, 30, -2, 1, 0), make_rect(4, 4, 0, 0, 0), 1'b1);
        add_case("aa_neg_touch", make_rect(6, 6, 0, 0, 0), make_rect(6, 6, -6, -1, 0), 1'b0);
        // Rotated B has world halves 2 in x and 10 in y
        add_case("rot90_overlap", make_rect(10, 4, 0, 0, 0), make_rect(20, 4, 6, 8, 1), 1'b1);
        add_case("rot90_separated", make_rect(10, 4, 0, 0, 0), make_rect(20, 4, 8, 0, 1),
                 1'b0);
        add_case("rot90_both", make_rect(10, 4, 0, 0, 1), make_rect(20, 4, 3, 14, 1), 1'b1);
    endtask

    task automatic add_random_cases(input int count);
        int wa;
        int ha;
        int wb;
        int hb;
        int ax;
        int ay;
        int bx;
        int by;
        bit exp;

        for (int n = 0; n < count; n++) begin
            wa  = next_below(24);
            ha  = next_below(24);
            wb  = next_below(24);
            hb  = next_below(24);
            ax  = next_below(24) - 12;
            ay  = next_below(24) - 12;
            bx  = next_below(24) - 12;
            by  = next_below(24) - 12;
            exp = expected_collision(bx - ax, by - ay, (wa >> 1) + (wb >> 1),
                                     (ha >> 1) + (hb >> 1));
            add_case($sformatf("random_%0d", n), make_rect(wa, ha, ax, ay, 1'b0),
                     make_rect(wb, hb, bx, by, 1'b0), exp);
        end
    endtask

    // Called right after a falling edge
    task automatic drive_pair(input int idx, input string tag);
        rect_a   = case_a[idx];
        rect_b   = case_b[idx];
        in_valid = 1'b1;
        pend_name.push_back({case_name[idx], tag});
        pend_flag.push_back(case_exp[idx]);
        pend_due.push_back(cycle_count + pipe_latency);
    endtask

    // Idle cycles carry a blank pair, which the DUT must ignore
    task automatic drive_idle();
        in_valid = 1'b0;
        rect_a   = '0;
        rect_b   = '0;
    endtask

    task automatic wait_for_results();
        int waited;

        waited = 0;
        while (pend_name.size() != 0 && waited < result_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (pend_name.size() != 0) begin
            $display("Result for %s never arrived within %0d cycles", pend_name[0],
                     result_timeout);
            timed_out = 1'b1;
            fail_count++;
        end
    endtask

    task automatic apply_table(input bit back_to_back, input string tag);
        int i;

        i = 0;
        while (i < case_name.size() && !timed_out) begin
            @(negedge clk);
            drive_pair(i, tag);
            if (!back_to_back) begin
                @(negedge clk);
                drive_idle();
                wait_for_results();
            end
            i++;
        end
        @(negedge clk);
        drive_idle();
        wait_for_results();
    endtask

    task automatic check_idle(input string when_txt, inout bit ok);
        assert (out_valid === 1'b0 && is_collision === 1'b0) else begin
            $display("[FAIL] reset (%s): expected out_valid 0 is_collision 0, actual %b %b",
                     when_txt, out_valid, is_collision);
            ok = 1'b0;
        end
    endtask

    // Each result is compared on the falling edge, when outputs are stable
    always @(negedge clk) begin : check_outputs
        string name;
        bit    flag;
        int    due;
        bit    ok;

        if (out_valid === 1'b1) begin
            assert (pend_name.size() != 0) else begin
                $display("out_valid rose with no pair in flight");
                fail_count++;
            end
            if (pend_name.size() != 0) begin
                name = pend_name.pop_front();
                flag = pend_flag.pop_front();
                due  = pend_due.pop_front();
                ok   = 1'b1;
                assert (is_collision === flag) else begin
                    $display("[FAIL] %s: expected %0b, actual %0b", name, flag, is_collision);
                    ok = 1'b0;
                end
                assert (cycle_count == due) else begin
                    $display("[FAIL] %s: expected arrival cycle %0d, actual %0d", name, due,
                             cycle_count);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("[PASS] %s", name);
                    pass_count++;
                end else begin
                    fail_count++;
                end
                last_name   = name;
                last_flag   = flag;
                have_result = 1'b1;
            end
        end else if (have_result) begin
            // Between results the flag keeps the last pair's answer
            assert (is_collision === last_flag) else begin
                $display("[FAIL] %s (hold): expected %0b, actual %0b", last_name, last_flag,
                         is_collision);
                fail_count++;
            end
        end
    end

    initial begin
        bit reset_ok;

        rst       = 1'b1;
        in_valid  = 1'b0;
        rect_a    = '0;
        rect_b    = '0;
        rng_state = 32'd2666;
        reset_ok  = 1'b1;

        add_directed_cases();
        add_random_cases(num_random);

        repeat (2) @(negedge clk);
        check_idle("during reset", reset_ok);
        rst = 1'b0;

        // No input, so the pipeline must stay quiet
        repeat (pipe_latency) begin
            @(negedge clk);
            check_idle("idle after reset", reset_ok);
        end
        if (reset_ok) begin
            $display("[PASS] reset");
            pass_count++;
        end else begin
            fail_count++;
        end

        apply_table(1'b0, "");
        if (!timed_out) begin
            apply_table(1'b1, "/b2b");
        end

        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/sat_pkg.sv
rtl/corner_decode.sv
rtl/axis_project.sv
rtl/separation_check.sv
rtl/collision_detector.sv
dv/clk_gen.sv
dv/collision_detector_tb.sv
